//--- hw/execPkg.sv
`default_nettype none

package execPkg;

	localparam int DataWidth = 32;
	localparam int ShamtWidth = 5;
	localparam int OpWidth = 5;
	localparam int CountWidth = $clog2(DataWidth + 1); // clo/clz span 0..32

	localparam int IssueDepth = 4; // also the upstream credit count
	localparam int OutCredits = 2;
	localparam int IdxWidth = $clog2(IssueDepth);
	localparam int CntWidth = $clog2(IssueDepth + 1);
	localparam int CreditWidth = $clog2(OutCredits + 1);

	// opcode map
	localparam logic [OpWidth-1:0] OpAdd = 5'b00000;
	localparam logic [OpWidth-1:0] OpSub = 5'b00001;
	localparam logic [OpWidth-1:0] OpOr = 5'b00010;
	localparam logic [OpWidth-1:0] OpAnd = 5'b00011;
	localparam logic [OpWidth-1:0] OpNor = 5'b00100;
	localparam logic [OpWidth-1:0] OpXor = 5'b00101;
	localparam logic [OpWidth-1:0] OpSll = 5'b00110;
	localparam logic [OpWidth-1:0] OpSrl = 5'b00111;
	localparam logic [OpWidth-1:0] OpSra = 5'b01000;
	localparam logic [OpWidth-1:0] OpSlt = 5'b01001;
	localparam logic [OpWidth-1:0] OpSltu = 5'b01010; // any unlisted code compares unsigned too
	localparam logic [OpWidth-1:0] OpMovA = 5'b01011; // movn/movz whose condition sits in writeback
	localparam logic [OpWidth-1:0] OpAddu = 5'b01100;
	localparam logic [OpWidth-1:0] OpClo = 5'b01101;
	localparam logic [OpWidth-1:0] OpClz = 5'b01110;
	localparam logic [OpWidth-1:0] OpSubu = 5'b10000;

	typedef struct packed {
		logic [OpWidth-1:0] op;
		logic [DataWidth-1:0] a;
		logic [DataWidth-1:0] b;
		logic [ShamtWidth-1:0] shamt;
		logic shamtSel; // 1 = shamt field, 0 = A[4:0]
	} aluOpT;

	typedef struct packed {
		logic [DataWidth-1:0] data;
		logic overflow;
	} aluResT;

	// ops served by the shift/count unit
	function automatic logic isShiftClass(input logic [OpWidth-1:0] op);
		return op inside {OpSll, OpSrl, OpSra, OpClo, OpClz};
	endfunction

endpackage

`default_nettype wire

//--- hw/issueQueue.sv
`timescale 1ns/1ps
`default_nettype none

module issueQueue (
	input wire logic clk,
	input wire logic arstN,
	input wire logic inValid,
	input execPkg::aluOpT inOp,
	input wire logic pop,
	output logic headValid,
	output execPkg::aluOpT headOp,
	output logic inCredit
);
	import execPkg::*;

	aluOpT mem [IssueDepth];
	logic [IdxWidth-1:0] wrPtr;
	logic [IdxWidth-1:0] rdPtr;
	logic [CntWidth-1:0] count;
	logic full;
	logic wrEn;

	assign full = (count == CntWidth'(IssueDepth));
	assign wrEn = inValid && !full;
	assign headValid = (count != '0);
	assign headOp = mem[rdPtr];

	// payload storage
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrPtr] <= inOp;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrEn) begin
				wrPtr <= wrPtr + 1'b1; // depth is a power of two
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({wrEn, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// one credit back per freed slot
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			inCredit <= 1'b0;
		end else begin
			inCredit <= pop;
		end
	end

	// upstream only sends with a credit in hand, so a full queue never sees a write
	assert property (@(posedge clk) disable iff (!arstN) inValid |-> !full)
		else $error("issueQueue: write while full");

	// merge stage only pops a valid head
	assert property (@(posedge clk) disable iff (!arstN) pop |-> count != '0)
		else $error("issueQueue: pop while empty");

endmodule

`default_nettype wire

//--- hw/intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu (
	input execPkg::aluOpT headOp,
	output execPkg::aluResT aluRes
);
	import execPkg::*;

	logic [DataWidth-1:0] a;
	logic [DataWidth-1:0] b;
	logic [DataWidth-1:0] sum;
	logic [DataWidth-1:0] diff;
	logic ltu;
	logic less;
	logic addOvf;
	logic subOvf;

	assign a = headOp.a;
	assign b = headOp.b;
	assign sum = a + b;
	assign diff = a - b;
	assign ltu = (a < b);

	// signed compare flips the unsigned one when signs differ
	assign less = (headOp.op == OpSlt && (a[DataWidth-1] ^ b[DataWidth-1])) ? ~ltu : ltu;

	// same-sign operands, result sign changed
	assign addOvf = (a[DataWidth-1] == b[DataWidth-1]) &&
		(sum[DataWidth-1] != a[DataWidth-1]);
	// opposite-sign operands, result takes B's sign
	assign subOvf = (a[DataWidth-1] != b[DataWidth-1]) &&
		(diff[DataWidth-1] != a[DataWidth-1]);

	always_comb begin
		case (headOp.op)
			OpAdd: aluRes.data = sum;
			OpSub: aluRes.data = diff;
			OpOr: aluRes.data = a | b;
			OpAnd: aluRes.data = a & b;
			OpNor: aluRes.data = ~(a | b);
			OpXor: aluRes.data = a ^ b;
			OpAddu: aluRes.data = sum;
			OpSubu: aluRes.data = diff;
			OpMovA: aluRes.data = a; // movn, movz
			default: aluRes.data = {{(DataWidth-1){1'b0}}, less}; // slt, sltu and the rest
		endcase
	end

	always_comb begin
		case (headOp.op)
			OpAdd: aluRes.overflow = addOvf;
			OpSub: aluRes.overflow = subOvf;
			default: aluRes.overflow = 1'b0; // unsigned forms never trap
		endcase
	end

endmodule

`default_nettype wire

//--- hw/shiftCount.sv
`timescale 1ns/1ps
`default_nettype none

module shiftCount (
	input execPkg::aluOpT headOp,
	output execPkg::aluResT shiftRes
);
	import execPkg::*;

	logic [ShamtWidth-1:0] amt;
	logic [DataWidth-1:0] a;
	logic [DataWidth-1:0] b;
	logic [CountWidth-1:0] cloCnt;
	logic [CountWidth-1:0] clzCnt;

	// run length of bitVal from the MSB down
	function automatic logic [CountWidth-1:0] leadCount(
		input logic [DataWidth-1:0] word,
		input logic bitVal
	);
		logic [CountWidth-1:0] cnt;
		logic run;
		cnt = '0;
		run = 1'b1;
		for (int i = DataWidth - 1; i >= 0; i--) begin
			if (run && word[i] == bitVal) begin
				cnt = cnt + 1'b1;
			end else begin
				run = 1'b0;
			end
		end
		return cnt;
	endfunction

	assign a = headOp.a;
	assign b = headOp.b;
	assign amt = headOp.shamtSel ? headOp.shamt : a[ShamtWidth-1:0]; // sllv/srlv/srav use A
	assign cloCnt = leadCount(a, 1'b1);
	assign clzCnt = leadCount(a, 1'b0);

	always_comb begin
		case (headOp.op)
			OpSll: shiftRes.data = b << amt;
			OpSrl: shiftRes.data = b >> amt;
			OpSra: shiftRes.data = $signed(b) >>> amt; // sign fill
			OpClo: shiftRes.data = {{(DataWidth-CountWidth){1'b0}}, cloCnt};
			OpClz: shiftRes.data = {{(DataWidth-CountWidth){1'b0}}, clzCnt};
			default: shiftRes.data = '0; // merge takes the ALU side
		endcase
	end

	assign shiftRes.overflow = 1'b0;

endmodule

`default_nettype wire

//--- hw/resultMerge.sv
`timescale 1ns/1ps
`default_nettype none

module resultMerge (
	input wire logic clk,
	input wire logic arstN,
	input wire logic headValid,
	input execPkg::aluOpT headOp,
	input execPkg::aluResT aluRes,
	input execPkg::aluResT shiftRes,
	input wire logic outCredit,
	output logic pop,
	output logic outValid,
	output execPkg::aluResT outRes
);
	import execPkg::*;

	logic [CreditWidth-1:0] credits;
	aluResT selRes;

	assign pop = headValid && (credits != '0);
	assign selRes = isShiftClass(headOp.op) ? shiftRes : aluRes;

	// downstream credit count
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			credits <= CreditWidth'(OutCredits);
		end else begin
			case ({pop, outCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits; // spend and return cancel out
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= pop;
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (pop) begin
			outRes <= selRes;
		end
	end

	// downstream never returns more than it was given
	assert property (@(posedge clk) disable iff (!arstN) credits <= CreditWidth'(OutCredits))
		else $error("resultMerge: credit count above %0d", OutCredits);

endmodule

`default_nettype wire

//--- hw/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
	input wire logic clk,
	input wire logic arstN,
	input wire logic inValid,
	input execPkg::aluOpT inOp,
	output logic inCredit,
	output logic outValid,
	output execPkg::aluResT outRes,
	input wire logic outCredit
);
	import execPkg::*;

	aluOpT headOp;
	logic headValid;
	logic pop;
	aluResT aluRes;
	aluResT shiftRes;

	issueQueue issueQueue (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inOp(inOp),
		.pop(pop),
		.headValid(headValid),
		.headOp(headOp),
		.inCredit(inCredit)
	);

	intAlu intAlu (
		.headOp(headOp),
		.aluRes(aluRes)
	);

	shiftCount shiftCount (
		.headOp(headOp),
		.shiftRes(shiftRes)
	);

	resultMerge resultMerge (
		.clk(clk),
		.arstN(arstN),
		.headValid(headValid),
		.headOp(headOp),
		.aluRes(aluRes),
		.shiftRes(shiftRes),
		.outCredit(outCredit),
		.pop(pop),
		.outValid(outValid),
		.outRes(outRes)
	);

endmodule

`default_nettype wire

//--- tb/execUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module execUnitTb;
	import execPkg::*;

	localparam int NumOps = 400;
	localparam int CycleLimit = 20 * NumOps + 100;
	localparam logic [31:0] LfsrTaps = 32'h80200003;

	localparam logic [OpWidth-1:0] KnownOps [16] = '{
		OpAdd, OpSub, OpOr, OpAnd, OpNor, OpXor, OpSll, OpSrl,
		OpSra, OpSlt, OpSltu, OpMovA, OpAddu, OpClo, OpClz, OpSubu
	};

	logic clk;
	logic arstN;
	logic inValid;
	aluOpT inOp;
	logic inCredit;
	logic outValid;
	aluResT outRes;
	logic outCredit;

	logic [31:0] lfsr;
	aluResT expQ [$]; // expected results in send order
	int dueQ [$]; // ticks at which a downstream credit goes back
	aluResT chkExp; // expected value of the result now on outRes
	int upCredits;
	int sent;
	int rxCount;
	int retCount;
	int creditPulses;
	int tick;
	int lastDue;
	int cycles = 0;
	logic sentAny = 1'b0;

	execUnit dut (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.inOp(inOp),
		.inCredit(inCredit),
		.outValid(outValid),
		.outRes(outRes),
		.outCredit(outCredit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(input string msg);
		abortRun($sformatf("Error at %0d ns: %s", $time, msg));
	endtask

	// one galois step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		logic lsb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ LfsrTaps;
			end
			val = {val[30:0], lsb};
		end
		return val;
	endfunction

	function automatic int leadRun(input logic [31:0] word, input logic bitVal);
		int n;
		n = 0;
		while (n < 32 && word[31 - n] == bitVal) begin
			n++;
		end
		return n;
	endfunction

	function automatic aluResT expectedResult(input aluOpT op);
		aluResT r;
		logic [32:0] wide;
		logic [4:0] amt;
		r = '0;
		amt = op.shamtSel ? op.shamt : op.a[4:0];
		case (op.op)
			OpAdd: begin
				wide = {op.a[31], op.a} + {op.b[31], op.b}; // one guard bit
				r.data = wide[31:0];
				r.overflow = wide[32] ^ wide[31];
			end
			OpSub: begin
				wide = {op.a[31], op.a} - {op.b[31], op.b};
				r.data = wide[31:0];
				r.overflow = wide[32] ^ wide[31];
			end
			OpAddu: r.data = op.a + op.b;
			OpSubu: r.data = op.a - op.b;
			OpOr: r.data = op.a | op.b;
			OpAnd: r.data = op.a & op.b;
			OpNor: r.data = ~(op.a | op.b);
			OpXor: r.data = op.a ^ op.b;
			OpSlt: r.data = ($signed(op.a) < $signed(op.b)) ? 32'd1 : 32'd0;
			OpMovA: r.data = op.a;
			OpSll: r.data = op.b << amt;
			OpSrl: r.data = op.b >> amt;
			OpSra: r.data = (op.b >> amt) | (op.b[31] ? ~(32'hffffffff >> amt) : 32'h0);
			OpClo: r.data = leadRun(op.a, 1'b1);
			OpClz: r.data = leadRun(op.a, 1'b0);
			default: r.data = (op.a < op.b) ? 32'd1 : 32'd0; // sltu and unlisted codes
		endcase
		return r;
	endfunction

	function automatic logic [31:0] pickOperand();
		logic [31:0] val;
		case (randBits(2))
			0: val = '0;
			1: val = '1;
			2: begin
				case (randBits(2))
					0: val = 32'h7fffffff;
					1: val = 32'h80000000;
					2: val = 32'h0000ffff;
					default: val = 32'hffff0000;
				endcase
			end
			default: val = randBits(32);
		endcase
		return val;
	endfunction

	function automatic aluOpT makeOp();
		aluOpT op;
		if (randBits(1)) begin
			op.op = KnownOps[4'(randBits(4))];
		end else begin
			op.op = OpWidth'(randBits(5)); // hits unlisted codes too
		end
		op.a = pickOperand();
		op.b = pickOperand();
		op.shamt = ShamtWidth'(randBits(5));
		op.shamtSel = 1'(randBits(1));
		return op;
	endfunction

	task automatic observeOutputs();
		int due;
		if (inCredit) begin
			creditPulses++;
			upCredits++;
			assert (upCredits <= IssueDepth)
				else abortRun("queue returned more credits than it has slots");
		end
		if (outValid) begin
			assert (expQ.size() > 0)
				else abortRun("a result arrived with no operation outstanding");
			chkExp = expQ.pop_front();
			rxCount++;
			due = tick + randBits(2); // 0..3 cycles of back-pressure
			if (due <= lastDue) begin
				due = lastDue + 1;
			end
			lastDue = due;
			dueQ.push_back(due);
		end
	endtask

	task automatic returnCredits();
		if (dueQ.size() > 0 && dueQ[0] <= tick) begin
			void'(dueQ.pop_front());
			outCredit = 1'b1;
			retCount++;
		end else begin
			outCredit = 1'b0;
		end
	endtask

	task automatic sendOperation();
		aluOpT op;
		if (sent < NumOps && upCredits > 0 && randBits(2) != 2'b00) begin
			op = makeOp();
			inOp = op;
			inValid = 1'b1;
			expQ.push_back(expectedResult(op));
			upCredits--;
			sent++;
			sentAny = 1'b1;
		end else begin
			inValid = 1'b0;
		end
	endtask

	assert property (@(posedge clk) disable iff (!arstN) outValid |-> outRes.data == chkExp.data)
		else reportMismatch($sformatf("result data %h, expected %h",
			$sampled(outRes.data), chkExp.data));

	assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> outRes.overflow == chkExp.overflow)
		else reportMismatch($sformatf("overflow %b, expected %b",
			$sampled(outRes.overflow), chkExp.overflow));

	// results held downstream never exceed the credits handed out
	assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> (rxCount - retCount) <= OutCredits)
		else reportMismatch($sformatf("%0d results held downstream with %0d credits",
			rxCount - retCount, OutCredits));

	assert property (@(posedge clk) disable iff (!arstN) !sentAny |-> !outValid && !inCredit)
		else reportMismatch("output activity before the first operation");

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			abortRun($sformatf("Timeout: run still busy after %0d cycles", cycles));
		end
	end

	initial begin
		lfsr = 32'hb50d;
		arstN = 1'b0;
		inValid = 1'b0;
		inOp = '0;
		outCredit = 1'b0;
		upCredits = IssueDepth;
		sent = 0;
		rxCount = 0;
		retCount = 0;
		creditPulses = 0;
		tick = 0;
		lastDue = 0;
		chkExp = '0;
		repeat (3) @(posedge clk);
		#1 arstN = 1'b1;

		while (rxCount < NumOps) begin
			@(posedge clk);
			#1;
			tick++;
			observeOutputs();
			returnCredits();
			sendOperation();
		end

		// let the last result meet its check
		@(posedge clk);
		#1;
		inValid = 1'b0;
		outCredit = 1'b0;
		@(posedge clk);
		#1;
		assert (creditPulses == NumOps)
			else reportMismatch($sformatf("%0d issue credits returned, expected %0d",
				creditPulses, NumOps));
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
hw/execPkg.sv
hw/issueQueue.sv
hw/intAlu.sv
hw/shiftCount.sv
hw/resultMerge.sv
hw/execUnit.sv
tb/execUnitTb.sv
